// ==== compile.f ====
+incdir+source
source/mips_codes_pkg.sv
source/mips_fsm.sv
source/mips_decode.sv
source/mips_pc.sv
source/mips_regfile.sv
source/mips_alu.sv
source/mips_cpu_bus.sv
sim/avalon_ram_model.sv
sim/mips_cpu_bus_assertions.sv
sim/mips_cpu_bus_tb.sv

// ==== sim/mips_cpu_bus_tb.sv ====
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_cpu_bus_tb;
  import mips_codes_pkg::*;

  localparam int NUM_TESTS  = 5;
  localparam int MAX_INSTR  = 64;
  localparam int MAX_CYCLES = NUM_TESTS * MAX_INSTR * (3 + 2 * 3) * 2;
  localparam int CODE_BASE  = 256;
  localparam int DATA_BASE  = 64;

  logic       clk;
  logic       rst_n = 1'b0;
  logic [1:0] stall = 2'd0;
  logic       force_stall = 1'b0;
  logic       active;
  logic       mem_read;
  logic       mem_write;
  logic       waitrequest;
  logic [3:0] byteenable;
  size_t      mem_addr;
  size_t      mem_wdata;
  size_t      mem_rdata;
  size_t      v0;

  size_t image [512];
  size_t ref_mem [512];
  size_t store_words [4];
  int    n_instr;
  size_t data_rng = 32'd92648;
  size_t stall_rng = 32'd92648;
  int    test_errors = 0;
  int    failed_tests = 0;
  int    test_count = 0;
  int    cycles = 0;
  size_t last_v0;
  size_t test2_v0;
  event  run_started;
  event  run_done;

  mips_cpu_bus uut (
    .clk          (clk),
    .rst_n_i      (rst_n),
    .active_o     (active),
    .register_v0_o(v0),
    .address_o    (mem_addr),
    .write_o      (mem_write),
    .read_o       (mem_read),
    .waitrequest_i(waitrequest),
    .writedata_o  (mem_wdata),
    .byteenable_o (byteenable),
    .readdata_i   (mem_rdata)
  );

  avalon_ram_model ram (
    .clk          (clk),
    .rst_n_i      (rst_n),
    .address_i    (mem_addr),
    .read_i       (mem_read),
    .write_i      (mem_write),
    .writedata_i  (mem_wdata),
    .byteenable_i (byteenable),
    .stall_i      (stall),
    .readdata_o   (mem_rdata),
    .waitrequest_o(waitrequest)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic size_t xorshift(input size_t x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic size_t next_word();
    data_rng = xorshift(data_rng);
    return data_rng;
  endfunction

  // Each access stalls 1 to 3 cycles when stalls are forced.
  always @(posedge clk) begin
    stall_rng = xorshift(stall_rng);
    stall <= force_stall ? 2'd1 + 2'(stall_rng % 3) : stall_rng[1:0];
  end

  function automatic size_t r_type(funct_t f, regaddr_t rd, regaddr_t rs, regaddr_t rt);
    return {OPCODE_SPECIAL, rs, rt, rd, 5'd0, f};
  endfunction

  function automatic size_t i_type(opcode_t op, regaddr_t rt, regaddr_t rs, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic int word_index(input size_t addr);
    return {addr[31], addr[9:2]};
  endfunction

  function automatic void clear_image();
    for (int i = 0; i < 512; i++) begin
      image[i] = '0;
    end
    n_instr = 0;
  endfunction

  function automatic void emit(input size_t word);
    image[CODE_BASE + n_instr] = word;
    n_instr++;
  endfunction

  function automatic void load_const(input regaddr_t r, input size_t value);
    emit(i_type(OPCODE_LUI, r, 5'd0, value[31:16]));
    emit(i_type(OPCODE_ORI, r, r, value[15:0]));
  endfunction

  // Instruction-set model of the subset that runs on ref_mem until a JR to the halt address.
  function automatic size_t mips_reference();
    size_t regs [`MIPS_NUM_REGS];
    size_t pc;
    size_t ins;
    size_t a;
    size_t b;
    size_t imm_s;
    for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
      regs[i] = '0;
    end
    pc = `MIPS_RESET_VECTOR;
    for (int step = 0; step < MAX_INSTR; step++) begin
      ins   = ref_mem[word_index(pc)];
      a     = regs[ins[25:21]];
      b     = regs[ins[20:16]];
      imm_s = {{16{ins[15]}}, ins[15:0]};
      pc    = pc + 32'd4;
      case (ins[31:26])
        OPCODE_SPECIAL: begin
          case (ins[5:0])
            FUNCT_ADDU: regs[ins[15:11]] = a + b;
            FUNCT_SUBU: regs[ins[15:11]] = a - b;
            FUNCT_AND:  regs[ins[15:11]] = a & b;
            FUNCT_OR:   regs[ins[15:11]] = a | b;
            FUNCT_XOR:  regs[ins[15:11]] = a ^ b;
            FUNCT_SLT:  regs[ins[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            FUNCT_JR: begin
              if (a == `MIPS_HALT_ADDR) begin
                return regs[2];
              end
              pc = a;
            end
            default: ;
          endcase
        end
        OPCODE_ADDIU: regs[ins[20:16]] = a + imm_s;
        OPCODE_ORI:   regs[ins[20:16]] = a | {16'h0000, ins[15:0]};
        OPCODE_LUI:   regs[ins[20:16]] = {ins[15:0], 16'h0000};
        OPCODE_LW:    regs[ins[20:16]] = ref_mem[word_index(a + imm_s)];
        OPCODE_SW:    ref_mem[word_index(a + imm_s)] = b;
        OPCODE_BEQ:   pc = (a == b) ? pc + (imm_s << 2) : pc;
        OPCODE_BNE:   pc = (a != b) ? pc + (imm_s << 2) : pc;
        default: ;
      endcase
      regs[0] = '0;
    end
    return '1;
  endfunction

  task automatic run_test();
    @(posedge clk);
    rst_n <= 1'b0;
    for (int i = 0; i < 512; i++) begin
      ram.mem[i] = image[i];
      ref_mem[i] = image[i];
    end
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    test_errors = 0;
    -> run_started;
    @(run_done);
  endtask

  task automatic finish_test(input string name);
    test_count++;
    if (test_errors != 0) begin
      failed_tests++;
    end
    $display("Test %0d (%s): %s", test_count, name, (test_errors == 0) ? "ok" : "FAILED");
  endtask

  // Stores four random words, loads them back and sums them into v0.
  task automatic build_load_store();
    clear_image();
    emit(i_type(OPCODE_ORI, 5'd4, 5'd0, 16'(DATA_BASE * 4)));
    for (int k = 0; k < 4; k++) begin
      load_const(5'd8, store_words[k]);
      emit(i_type(OPCODE_SW, 5'd8, 5'd4, 16'(4 * k)));
    end
    for (int k = 0; k < 4; k++) begin
      emit(i_type(OPCODE_LW, 5'd9, 5'd4, 16'(4 * k)));
      emit(r_type(FUNCT_ADDU, 5'd2, 5'd2, 5'd9));
    end
    emit(r_type(FUNCT_JR, 5'd0, 5'd0, 5'd0));
  endtask

  // Waits for the halt and then checks the results and the quiet bus.
  initial begin
    size_t exp_v0;
    forever begin
      @(run_started);
      @(negedge clk);
      while (active) @(negedge clk);
      exp_v0 = mips_reference();
      assert (v0 === exp_v0) else begin
        $display("Error at %0t ns: v0 is %h, expected %h", $time, v0, exp_v0);
        test_errors++;
      end
      for (int i = 0; i < CODE_BASE; i++) begin
        assert (ram.mem[i] === ref_mem[i]) else begin
          $display("Error at %0t ns: data word %0d is %h, expected %h",
                   $time, i, ram.mem[i], ref_mem[i]);
          test_errors++;
        end
      end
      repeat (20) begin
        @(negedge clk);
        assert (!active && !mem_read && !mem_write) else begin
          $display("Error at %0t ns: core became active or used the bus after halt", $time);
          test_errors++;
        end
      end
      last_v0 = v0;
      -> run_done;
    end
  end

  initial begin
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles: the core never halted", MAX_CYCLES);
    $display("Test failures found");
    $finish;
  end

  initial begin
    size_t word;
    int    trip;

    clear_image();
    load_const(5'd8, next_word());
    load_const(5'd9, next_word());
    emit(r_type(FUNCT_ADDU, 5'd10, 5'd8, 5'd9));
    emit(r_type(FUNCT_SUBU, 5'd11, 5'd8, 5'd9));
    emit(r_type(FUNCT_AND, 5'd12, 5'd8, 5'd9));
    emit(r_type(FUNCT_OR, 5'd13, 5'd8, 5'd9));
    emit(r_type(FUNCT_XOR, 5'd14, 5'd8, 5'd9));
    emit(r_type(FUNCT_SLT, 5'd15, 5'd8, 5'd9));
    word = next_word();
    emit(i_type(OPCODE_ADDIU, 5'd16, 5'd10, word[15:0]));
    // Fold every result into v0.
    emit(r_type(FUNCT_OR, 5'd2, 5'd10, 5'd0));
    for (int r = 11; r <= 16; r++) begin
      emit(r_type((r % 2) ? FUNCT_XOR : FUNCT_ADDU, 5'd2, 5'd2, 5'(r)));
    end
    emit(r_type(FUNCT_JR, 5'd0, 5'd0, 5'd0));
    run_test();
    finish_test("arithmetic and logic");

    for (int k = 0; k < 4; k++) begin
      store_words[k] = next_word();
    end
    build_load_store();
    run_test();
    test2_v0 = last_v0;
    finish_test("load and store");

    // A countdown loop is followed by a taken BEQ over a poison ADDIU.
    trip = 1 + (next_word() % 12);
    clear_image();
    emit(i_type(OPCODE_ORI, 5'd8, 5'd0, 16'(trip)));
    emit(i_type(OPCODE_ADDIU, 5'd2, 5'd2, 16'd1));
    emit(i_type(OPCODE_ADDIU, 5'd8, 5'd8, 16'hFFFF));
    emit(i_type(OPCODE_BNE, 5'd0, 5'd8, 16'hFFFD));
    emit(i_type(OPCODE_BEQ, 5'd0, 5'd0, 16'd1));
    emit(i_type(OPCODE_ADDIU, 5'd2, 5'd2, 16'd100));
    emit(r_type(FUNCT_JR, 5'd0, 5'd0, 5'd0));
    run_test();
    finish_test("branches");

    // Code after the JR must never run.
    clear_image();
    emit(i_type(OPCODE_ORI, 5'd2, 5'd0, 16'h0055));
    emit(i_type(OPCODE_ORI, 5'd4, 5'd0, 16'(DATA_BASE * 4)));
    emit(r_type(FUNCT_JR, 5'd0, 5'd0, 5'd0));
    emit(i_type(OPCODE_SW, 5'd2, 5'd4, 16'd0));
    emit(i_type(OPCODE_ORI, 5'd2, 5'd0, 16'h00AA));
    run_test();
    finish_test("halt");

    force_stall <= 1'b1;
    build_load_store();
    run_test();
    assert (last_v0 === test2_v0) else begin
      $display("Error at %0t ns: stalled v0 %h differs from unforced run %h",
               $time, last_v0, test2_v0);
      test_errors++;
    end
    finish_test("waitrequest stalls");

    $display("Summary: %0d tests, %0d failed, %0d bus assertion failures",
             test_count, failed_tests, uut.bus_checks.fail_count);
    if (failed_tests == 0 && uut.bus_checks.fail_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== sim/mips_cpu_bus_assertions.sv ====
`timescale 1ns/1ps

module mips_cpu_bus_assertions (
  input logic                  clk,
  input logic                  rst_n_i,
  input logic                  active_o,
  input mips_codes_pkg::size_t address_o,
  input logic                  read_o,
  input logic                  write_o,
  input mips_codes_pkg::size_t writedata_o,
  input logic                  waitrequest_i
);

  // Number of failed assertions so far.
  int fail_count = 0;

  rw_exclusive: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(read_o && write_o))
    else begin
      $error("read_o and write_o are high together");
      fail_count++;
    end

  // A stalled request must hold everything until the slave accepts it.
  request_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    (read_o || write_o) && waitrequest_i |=> $stable(address_o) && $stable(read_o)
      && $stable(write_o) && $stable(writedata_o))
    else begin
      $error("Bus request changed while waitrequest_i was high");
      fail_count++;
    end

  word_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
    address_o[1:0] == 2'b00)
    else begin
      $error("address_o is not word aligned");
      fail_count++;
    end

  halt_sticky: assert property (@(posedge clk) disable iff (!rst_n_i)
    !active_o |=> !active_o)
    else begin
      $error("active_o rose again without a reset");
      fail_count++;
    end

endmodule

bind mips_cpu_bus mips_cpu_bus_assertions bus_checks (.*);

// ==== sim/avalon_ram_model.sv ====
`timescale 1ns/1ps

module avalon_ram_model (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  mips_codes_pkg::size_t address_i,
  input  logic                  read_i,
  input  logic                  write_i,
  input  mips_codes_pkg::size_t writedata_i,
  input  logic [3:0]            byteenable_i,
  input  logic [1:0]            stall_i,
  output mips_codes_pkg::size_t readdata_o,
  output logic                  waitrequest_o
);
  import mips_codes_pkg::*;

  // Upper half holds code at the reset vector, lower half the data region.
  size_t      mem [512];
  logic [8:0] index;
  logic       request;
  logic       started_q;
  logic [1:0] left_q;

  assign index   = {address_i[31], address_i[9:2]};
  assign request = read_i || write_i;

  // The stall length is sampled in the first cycle of each access.
  assign waitrequest_o = request && (started_q ? (left_q != 2'd0) : (stall_i != 2'd0));
  assign readdata_o    = mem[index];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      started_q <= 1'b0;
      left_q    <= 2'd0;
    end else if (request && waitrequest_o) begin
      started_q <= 1'b1;
      left_q    <= (started_q ? left_q : stall_i) - 2'd1;
    end else begin
      started_q <= 1'b0;
    end
  end

  always @(posedge clk) begin
    if (write_i && !waitrequest_o) begin
      for (int b = 0; b < 4; b++) begin
        if (byteenable_i[b]) begin
          mem[index][8*b +: 8] <= writedata_i[8*b +: 8];
        end
      end
    end
  end

endmodule

// ==== source/mips_cpu_bus.sv ====
`timescale 1ns/1ps

module mips_cpu_bus (
  input  logic                  clk,
  input  logic                  rst_n_i,
  output logic                  active_o,
  output mips_codes_pkg::size_t register_v0_o,

  // Avalon master port.
  output mips_codes_pkg::size_t address_o,
  output logic                  write_o,
  output logic                  read_o,
  input  logic                  waitrequest_i,
  output mips_codes_pkg::size_t writedata_o,
  output logic [3:0]            byteenable_o,
  input  mips_codes_pkg::size_t readdata_i
);
  import mips_codes_pkg::*;

  state_t   state;
  instr_t   instr;
  ctrl_t    ctrl;
  logic     is_mem;
  logic     halt;
  size_t    pc;
  regaddr_t addr_3;
  size_t    rs_data;
  size_t    rt_data;
  size_t    write_data_3;
  size_t    imm_ext;
  size_t    alu_b;
  size_t    alu_result;
  logic     alu_zero;
  size_t    mem_addr_q;

  mips_fsm fsm (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .waitrequest_i(waitrequest_i),
    .is_mem_i     (is_mem),
    .halt_i       (halt),
    .state_o      (state)
  );

  mips_decode decode (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .state_i      (state),
    .waitrequest_i(waitrequest_i),
    .readdata_i   (readdata_i),
    .instr_o      (instr),
    .ctrl_o       (ctrl),
    .is_mem_o     (is_mem)
  );

  mips_pc pc_reg (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .ctrl_i     (ctrl),
    .immediate_i(instr.low.immediate),
    .rs_data_i  (rs_data),
    .alu_zero_i (alu_zero),
    .pc_o       (pc),
    .halt_o     (halt)
  );

  // Write-back goes to rd for R-type, otherwise to rt.
  assign addr_3       = ctrl.reg_a3_rd ? instr.low.r.rd : instr.rt;
  assign write_data_3 = ctrl.reg_wd_mem ? readdata_i : alu_result;

  mips_regfile regfile (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .addr_1_i      (instr.rs),
    .addr_2_i      (instr.rt),
    .addr_3_i      (addr_3),
    .write_data_3_i(write_data_3),
    .write_enable_i(ctrl.reg_wen),
    .read_data_1_o (rs_data),
    .read_data_2_o (rt_data),
    .v0_o          (register_v0_o)
  );

  assign imm_ext = ctrl.imm_zero_ext ? {16'h0000, instr.low.immediate}
                                     : {{16{instr.low.immediate[15]}}, instr.low.immediate};
  assign alu_b   = ctrl.src_b_imm ? imm_ext : rt_data;

  mips_alu alu (
    .alu_op_i(ctrl.alu_op),
    .a_i     (rs_data),
    .b_i     (alu_b),
    .result_o(alu_result),
    .zero_o  (alu_zero)
  );

  // Load/store address, held steady through the whole MEM state.
  always_ff @(posedge clk) begin
    if (state == EXEC) begin
      mem_addr_q <= alu_result;
    end
  end

  assign address_o    = ctrl.addr_sel_alu ? mem_addr_q : pc;
  assign read_o       = ctrl.mem_read;
  assign write_o      = ctrl.mem_write;
  assign writedata_o  = rt_data;
  assign byteenable_o = 4'b1111;
  assign active_o     = (state != HALTED);

endmodule

// ==== source/mips_alu.sv ====
`timescale 1ns/1ps

module mips_alu (
  input  mips_codes_pkg::alu_op_t alu_op_i,
  input  mips_codes_pkg::size_t   a_i,
  input  mips_codes_pkg::size_t   b_i,
  output mips_codes_pkg::size_t   result_o,
  output logic                    zero_o
);
  import mips_codes_pkg::*;

  always_comb begin
    case (alu_op_i)
      ALU_ADD: begin
        result_o = a_i + b_i;
      end
      ALU_SUB: begin
        result_o = a_i - b_i;
      end
      ALU_AND: begin
        result_o = a_i & b_i;
      end
      ALU_OR: begin
        result_o = a_i | b_i;
      end
      ALU_XOR: begin
        result_o = a_i ^ b_i;
      end
      // Signed compare, result is 0 or 1.
      ALU_SLT: begin
        result_o = {31'b0, $signed(a_i) < $signed(b_i)};
      end
      // Immediate moves to the upper half.
      ALU_LUI: begin
        result_o = {b_i[15:0], 16'h0000};
      end
      default: begin
        result_o = '0;
      end
    endcase
  end

  // Drives the branch decision, after a subtract.
  assign zero_o = (result_o == '0);

endmodule

// ==== source/mips_regfile.sv ====
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_regfile (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  mips_codes_pkg::regaddr_t addr_1_i,
  input  mips_codes_pkg::regaddr_t addr_2_i,
  input  mips_codes_pkg::regaddr_t addr_3_i,
  input  mips_codes_pkg::size_t    write_data_3_i,
  input  logic                     write_enable_i,
  output mips_codes_pkg::size_t    read_data_1_o,
  output mips_codes_pkg::size_t    read_data_2_o,
  output mips_codes_pkg::size_t    v0_o
);
  import mips_codes_pkg::*;

  size_t regs [`MIPS_NUM_REGS];

  // Register zero is cleared by reset and never written after.
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable_i && (addr_3_i != '0)) begin
      regs[addr_3_i] <= write_data_3_i;
    end
  end

  assign read_data_1_o = regs[addr_1_i];
  assign read_data_2_o = regs[addr_2_i];

  // Result register, shown on the core boundary.
  assign v0_o = regs[2];

endmodule

// ==== source/mips_pc.sv ====
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_pc (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  mips_codes_pkg::ctrl_t ctrl_i,
  input  logic [15:0]           immediate_i,
  input  mips_codes_pkg::size_t rs_data_i,
  input  logic                  alu_zero_i,
  output mips_codes_pkg::size_t pc_o,
  output logic                  halt_o
);
  import mips_codes_pkg::*;

  size_t pc_q;
  size_t pc_plus4;
  size_t branch_target;
  size_t pc_next;
  logic  branch_taken;

  assign pc_plus4      = pc_q + 32'd4;
  assign branch_target = pc_plus4 + {{14{immediate_i[15]}}, immediate_i, 2'b00};

  // BEQ wants a zero difference, BNE a non-zero one.
  assign branch_taken = ctrl_i.branch && (alu_zero_i != ctrl_i.branch_ne);

  always_comb begin
    if (ctrl_i.jump_reg) begin
      pc_next = rs_data_i;
    end else if (branch_taken) begin
      pc_next = branch_target;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= `MIPS_RESET_VECTOR;
    end else if (ctrl_i.pc_wen) begin
      pc_q <= pc_next;
    end
  end

  assign pc_o   = pc_q;
  assign halt_o = ctrl_i.pc_wen && ctrl_i.jump_reg && (rs_data_i == `MIPS_HALT_ADDR);

endmodule

// ==== source/mips_decode.sv ====
`timescale 1ns/1ps

module mips_decode (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  mips_codes_pkg::state_t state_i,
  input  logic                   waitrequest_i,
  input  mips_codes_pkg::size_t  readdata_i,
  output mips_codes_pkg::instr_t instr_o,
  output mips_codes_pkg::ctrl_t  ctrl_o,
  output logic                   is_mem_o
);
  import mips_codes_pkg::*;

  instr_t ir_q;
  logic   is_load;
  logic   writes_reg;

  // Instruction register, loaded once per completed fetch.
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ir_q <= '0;
    end else if (ctrl_o.ir_wen) begin
      ir_q <= instr_t'(readdata_i);
    end
  end

  assign instr_o  = ir_q;
  assign is_load  = (ir_q.opcode == OPCODE_LW);
  assign is_mem_o = is_load || (ir_q.opcode == OPCODE_SW);

  always_comb begin
    ctrl_o        = '0;
    ctrl_o.alu_op = ALU_ADD;
    writes_reg    = 1'b0;

    // Datapath steering depends on the instruction only.
    case (ir_q.opcode)
      OPCODE_SPECIAL: begin
        ctrl_o.reg_a3_rd = 1'b1;
        writes_reg       = 1'b1;
        case (ir_q.low.r.funct)
          FUNCT_ADDU: ctrl_o.alu_op = ALU_ADD;
          FUNCT_SUBU: ctrl_o.alu_op = ALU_SUB;
          FUNCT_AND:  ctrl_o.alu_op = ALU_AND;
          FUNCT_OR:   ctrl_o.alu_op = ALU_OR;
          FUNCT_XOR:  ctrl_o.alu_op = ALU_XOR;
          FUNCT_SLT:  ctrl_o.alu_op = ALU_SLT;
          FUNCT_JR: begin
            ctrl_o.jump_reg = 1'b1;
            writes_reg      = 1'b0;
          end
          // Unsupported function codes retire as a no-op.
          default: writes_reg = 1'b0;
        endcase
      end
      OPCODE_ADDIU: begin
        ctrl_o.src_b_imm = 1'b1;
        writes_reg       = 1'b1;
      end
      OPCODE_ORI: begin
        ctrl_o.src_b_imm    = 1'b1;
        ctrl_o.imm_zero_ext = 1'b1;
        ctrl_o.alu_op       = ALU_OR;
        writes_reg          = 1'b1;
      end
      OPCODE_LUI: begin
        ctrl_o.src_b_imm = 1'b1;
        ctrl_o.alu_op    = ALU_LUI;
        writes_reg       = 1'b1;
      end
      OPCODE_LW, OPCODE_SW: begin
        ctrl_o.src_b_imm = 1'b1;
      end
      OPCODE_BEQ, OPCODE_BNE: begin
        ctrl_o.branch    = 1'b1;
        ctrl_o.branch_ne = (ir_q.opcode == OPCODE_BNE);
        ctrl_o.alu_op    = ALU_SUB;
      end
      default: ;
    endcase

    // Enables fire once per instruction, and never while the bus stalls.
    case (state_i)
      FETCH: begin
        ctrl_o.mem_read = 1'b1;
        ctrl_o.ir_wen   = !waitrequest_i;
      end
      EXEC: begin
        ctrl_o.reg_wen = writes_reg;
        ctrl_o.pc_wen  = !is_mem_o;
      end
      MEM: begin
        ctrl_o.addr_sel_alu = 1'b1;
        ctrl_o.mem_read     = is_load;
        ctrl_o.mem_write    = !is_load;
        ctrl_o.reg_wd_mem   = is_load;
        ctrl_o.reg_wen      = is_load && !waitrequest_i;
        ctrl_o.pc_wen       = !waitrequest_i;
      end
      default: ;
    endcase
  end

endmodule

// ==== source/mips_fsm.sv ====
`timescale 1ns/1ps

module mips_fsm (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   waitrequest_i,
  input  logic                   is_mem_i,
  input  logic                   halt_i,
  output mips_codes_pkg::state_t state_o
);
  import mips_codes_pkg::*;

  state_t state_q;
  state_t state_d;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= FETCH;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      // A bus request is always pending here, so wait for the slave.
      FETCH: begin
        if (!waitrequest_i) begin
          state_d = EXEC;
        end
      end
      EXEC: begin
        if (halt_i) begin
          state_d = HALTED;
        end else if (is_mem_i) begin
          state_d = MEM;
        end else begin
          state_d = FETCH;
        end
      end
      MEM: begin
        if (!waitrequest_i) begin
          state_d = FETCH;
        end
      end
      // Only reset leaves this state.
      HALTED: begin
        state_d = HALTED;
      end
      default: begin
        state_d = FETCH;
      end
    endcase
  end

  assign state_o = state_q;

endmodule

// ==== source/mips_codes_pkg.sv ====
package mips_codes_pkg;

  typedef logic [31:0] size_t;
  typedef logic [4:0] regaddr_t;

  // Instruction cycle.
  typedef enum logic [1:0] {
    FETCH  = 2'd0,
    EXEC   = 2'd1,
    MEM    = 2'd2,
    HALTED = 2'd3
  } state_t;

  // Major opcodes, bits 31:26.
  typedef enum logic [5:0] {
    OPCODE_SPECIAL = 6'h00,
    OPCODE_BEQ     = 6'h04,
    OPCODE_BNE     = 6'h05,
    OPCODE_ADDIU   = 6'h09,
    OPCODE_ORI     = 6'h0D,
    OPCODE_LUI     = 6'h0F,
    OPCODE_LW      = 6'h23,
    OPCODE_SW      = 6'h2B
  } opcode_t;

  // Function field of SPECIAL instructions.
  typedef enum logic [5:0] {
    FUNCT_JR   = 6'h08,
    FUNCT_ADDU = 6'h21,
    FUNCT_SUBU = 6'h23,
    FUNCT_AND  = 6'h24,
    FUNCT_OR   = 6'h25,
    FUNCT_XOR  = 6'h26,
    FUNCT_SLT  = 6'h2A
  } funct_t;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLT = 3'd5,
    ALU_LUI = 3'd6
  } alu_op_t;

  // Low half of an instruction, read as R-type fields or as an immediate.
  typedef struct packed {
    regaddr_t rd;
    logic [4:0] shamt;
    funct_t funct;
  } rfields_t;

  typedef union packed {
    rfields_t r;
    logic [15:0] immediate;
  } low_t;

  typedef struct packed {
    opcode_t opcode;
    regaddr_t rs;
    regaddr_t rt;
    low_t low;
  } instr_t;

  typedef struct packed {
    logic pc_wen;
    logic ir_wen;
    logic reg_wen;
    logic mem_read;
    logic mem_write;
    logic src_b_imm;
    logic imm_zero_ext;
    logic addr_sel_alu;
    logic reg_wd_mem;
    logic reg_a3_rd;
    logic branch;
    logic branch_ne;
    logic jump_reg;
    alu_op_t alu_op;
  } ctrl_t;

endpackage

// ==== source/mips_config.svh ====
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Address of the first instruction fetch after reset.
`define MIPS_RESET_VECTOR 32'hBFC0_0000

// A JR to this address stops the core.
`define MIPS_HALT_ADDR 32'h0000_0000

// Architectural register count.
`define MIPS_NUM_REGS 32

`endif
